// ==== logic/noc_pkg.sv ====
// mesh router shared types
// ports, flits, headers and XY routing

package noc_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  localparam int num_ports  = 5;
  localparam int port_w     = 3;
  localparam int coord_w    = 3;
  localparam int data_w     = 32;
  localparam int fifo_depth = 4;
  localparam int fifo_aw    = $clog2(fifo_depth);

  // source and destination take two coordinates each
  localparam int hdr_rsv_w = data_w - 4 * coord_w - num_ports;

  //////////////////////////////
  // ports and directions
  //////////////////////////////

  typedef enum logic [port_w-1:0] {
    port_north = 3'd0,
    port_south = 3'd1,
    port_west  = 3'd2,
    port_east  = 3'd3,
    port_local = 3'd4
  } port_e;

  typedef struct packed {
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
  } xy_t;

  // one-hot, bit n selects port_e value n
  typedef logic [num_ports-1:0] dir_t;

  //////////////////////////////
  // flits
  //////////////////////////////

  typedef struct packed {
    logic              head;
    logic              tail;
    logic [data_w-1:0] data;
  } flit_t;

  // view of a head flit payload, routing field in the low bits
  typedef struct packed {
    xy_t                  src;
    xy_t                  dst;
    logic [hdr_rsv_w-1:0] reserved;
    dir_t                 routing;
  } header_t;

  // what an input port shows to every output
  typedef struct packed {
    logic  valid;
    flit_t flit;
    dir_t  req;
  } port_req_t;

  typedef enum logic [1:0] {
    st_reserve = 2'd0,
    st_head    = 2'd1,
    st_payload = 2'd2
  } out_state_e;

  // XY dimension order, x first
  // north is y - 1, east is x + 1
  function automatic dir_t next_hop(xy_t pos, xy_t dst);
    dir_t dir;
    dir = '0;
    if (dst.x > pos.x) begin
      dir[port_east] = 1'b1;
    end else if (dst.x < pos.x) begin
      dir[port_west] = 1'b1;
    end else if (dst.y < pos.y) begin
      dir[port_north] = 1'b1;
    end else if (dst.y > pos.y) begin
      dir[port_south] = 1'b1;
    end else begin
      dir[port_local] = 1'b1;
    end
    return dir;
  endfunction

endpackage

// ==== logic/input_port.sv ====
// router input port
// flit FIFO and worm request tracking

module input_port (
  input  logic                clk,
  input  logic                rst,
  input  noc_pkg::flit_t      data_i,
  input  logic                data_void_i,
  input  logic                rd_i,
  output logic                stop_o,
  output noc_pkg::port_req_t  req_o
);

  //////////////////////////////
  // storage
  //////////////////////////////

  noc_pkg::flit_t mem [noc_pkg::fifo_depth];

  logic [noc_pkg::fifo_aw-1:0] wr_ptr;
  logic [noc_pkg::fifo_aw-1:0] rd_ptr;
  logic [noc_pkg::fifo_aw:0]   count;

  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;

  noc_pkg::flit_t   head_flit;
  noc_pkg::header_t head_hdr;
  noc_pkg::dir_t    worm_req;

  assign full  = (count == noc_pkg::fifo_depth);
  assign empty = (count == '0);

  // upstream holds off while stop is high, full check is a guard
  assign wr_en = ~data_void_i & ~full;
  assign rd_en = rd_i & ~empty;

  assign stop_o = full;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  //////////////////////////////
  // worm request
  //////////////////////////////

  assign head_flit = mem[rd_ptr];
  assign head_hdr  = noc_pkg::header_t'(head_flit.data);

  // latched when the head leaves, dropped with the tail
  always_ff @(posedge clk) begin
    if (rst) begin
      worm_req <= '0;
    end else if (rd_en) begin
      if (head_flit.tail) begin
        worm_req <= '0;
      end else if (head_flit.head) begin
        worm_req <= head_hdr.routing;
      end
    end
  end

  always_comb begin
    req_o.valid = ~empty;
    req_o.flit  = head_flit;
    if (~empty && head_flit.head) begin
      req_o.req = head_hdr.routing;
    end else begin
      req_o.req = worm_req;
    end
  end

endmodule

// ==== logic/wormhole_arbiter.sv ====
// round-robin wormhole arbiter

module wormhole_arbiter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [noc_pkg::num_ports-1:0] req_i,
  input  logic                          lock_i,
  input  logic                          release_i,
  output logic [noc_pkg::num_ports-1:0] grant_o
);

  logic [noc_pkg::port_w-1:0]    ptr;
  logic [noc_pkg::port_w-1:0]    held_idx;
  logic [noc_pkg::port_w-1:0]    win_idx;
  logic                          locked;
  logic [noc_pkg::num_ports-1:0] rr_grant;

  // first requester at or after the pointer wins
  always_comb begin : rr_pick
    int   idx;
    logic found;
    rr_grant = '0;
    win_idx  = ptr;
    found    = 1'b0;
    for (int k = 0; k < noc_pkg::num_ports; k++) begin
      idx = int'(ptr) + k;
      if (idx >= noc_pkg::num_ports) begin
        idx = idx - noc_pkg::num_ports;
      end
      if (!found && req_i[idx]) begin
        rr_grant[idx] = 1'b1;
        win_idx       = idx[noc_pkg::port_w-1:0];
        found         = 1'b1;
      end
    end
  end

  // held grant covers the whole worm
  assign grant_o = locked ? (noc_pkg::dir_t'(1) << held_idx) : rr_grant;

  always_ff @(posedge clk) begin
    if (rst) begin
      locked   <= 1'b0;
      held_idx <= '0;
      ptr      <= '0;
    end else if (release_i) begin
      locked <= 1'b0;
      // priority moves just past the finished worm
      if (held_idx == noc_pkg::port_local) begin
        ptr <= '0;
      end else begin
        ptr <= held_idx + 1'b1;
      end
    end else if (lock_i) begin
      locked   <= 1'b1;
      held_idx <= win_idx;
    end
  end

endmodule

// ==== logic/lookahead_route.sv ====
// look-ahead route update

module lookahead_route (
  input  noc_pkg::xy_t   position_i,
  input  noc_pkg::port_e out_port_i,
  input  noc_pkg::flit_t flit_i,
  output noc_pkg::flit_t flit_o
);

  noc_pkg::xy_t     nbr;
  noc_pkg::header_t hdr;

  // coordinate of the router on the far side of this output
  always_comb begin
    nbr = position_i;
    case (out_port_i)
      noc_pkg::port_north: nbr.y = position_i.y - 1'b1;
      noc_pkg::port_south: nbr.y = position_i.y + 1'b1;
      noc_pkg::port_west:  nbr.x = position_i.x - 1'b1;
      noc_pkg::port_east:  nbr.x = position_i.x + 1'b1;
      default:             nbr   = position_i;
    endcase
  end

  always_comb begin
    hdr    = noc_pkg::header_t'(flit_i.data);
    flit_o = flit_i;
    if (flit_i.head) begin
      if (out_port_i == noc_pkg::port_local) begin
        hdr.routing = noc_pkg::dir_t'(1) << noc_pkg::port_local;
      end else begin
        hdr.routing = noc_pkg::next_hop(nbr, hdr.dst);
      end
      flit_o.data = hdr;
    end
  end

endmodule

// ==== logic/output_port.sv ====
// router output port
// arbitration, worm FSM and output register

module output_port #(
  parameter noc_pkg::port_e out_port = noc_pkg::port_local
) (
  input  logic                                          clk,
  input  logic                                          rst,
  input  noc_pkg::xy_t                                  position_i,
  input  noc_pkg::port_req_t [noc_pkg::num_ports-1:0]   reqs_i,
  input  logic                                          stop_i,
  output logic [noc_pkg::num_ports-1:0]                 rd_o,
  output noc_pkg::flit_t                                data_o,
  output logic                                          data_void_o
);

  logic [noc_pkg::num_ports-1:0] req_vec;
  logic [noc_pkg::num_ports-1:0] grant;

  noc_pkg::flit_t sel_flit;
  noc_pkg::flit_t fwd_flit;
  logic           sel_valid;
  logic           take;
  logic           arb_lock;
  logic           arb_release;

  noc_pkg::out_state_e state;
  noc_pkg::out_state_e state_nxt;

  //////////////////////////////
  // arbitration and select
  //////////////////////////////

  always_comb begin
    sel_flit  = '0;
    sel_valid = 1'b0;
    for (int i = 0; i < noc_pkg::num_ports; i++) begin
      req_vec[i] = reqs_i[i].valid & reqs_i[i].req[out_port];
      if (grant[i]) begin
        sel_flit  = sel_flit | reqs_i[i].flit;
        sel_valid = sel_valid | reqs_i[i].valid;
      end
    end
  end

  wormhole_arbiter u_arb (
    .clk       (clk),
    .rst       (rst),
    .req_i     (req_vec),
    .lock_i    (arb_lock),
    .release_i (arb_release),
    .grant_o   (grant)
  );

  lookahead_route u_la (
    .position_i (position_i),
    .out_port_i (out_port),
    .flit_i     (sel_flit),
    .flit_o     (fwd_flit)
  );

  // one flit per cycle once the worm owns the output
  assign take        = (state != noc_pkg::st_reserve) & sel_valid & ~stop_i;
  assign rd_o        = grant & {noc_pkg::num_ports{take}};
  assign arb_lock    = (state == noc_pkg::st_reserve) & (|grant);
  assign arb_release = take & sel_flit.tail;

  //////////////////////////////
  // worm FSM
  //////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      noc_pkg::st_reserve: begin
        if (|grant) begin
          state_nxt = noc_pkg::st_head;
        end
      end
      noc_pkg::st_head: begin
        if (take) begin
          state_nxt = sel_flit.tail ? noc_pkg::st_reserve : noc_pkg::st_payload;
        end
      end
      noc_pkg::st_payload: begin
        if (take && sel_flit.tail) begin
          state_nxt = noc_pkg::st_reserve;
        end
      end
      default: state_nxt = noc_pkg::st_reserve;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= noc_pkg::st_reserve;
    end else begin
      state <= state_nxt;
    end
  end

  // output register, frozen while downstream says stop
  always_ff @(posedge clk) begin
    if (take) begin
      data_o <= fwd_flit;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      data_void_o <= 1'b1;
    end else if (!stop_i) begin
      data_void_o <= ~take;
    end
  end

endmodule

// ==== logic/mesh_router.sv ====
// five port mesh router
// XY wormhole routing with look-ahead

module mesh_router (
  input  logic                                      clk,
  input  logic                                      rst,
  input  noc_pkg::xy_t                              position_i,
  input  noc_pkg::flit_t [noc_pkg::num_ports-1:0]   data_i,
  input  logic [noc_pkg::num_ports-1:0]             data_void_i,
  output logic [noc_pkg::num_ports-1:0]             stop_o,
  output noc_pkg::flit_t [noc_pkg::num_ports-1:0]   data_o,
  output logic [noc_pkg::num_ports-1:0]             data_void_o,
  input  logic [noc_pkg::num_ports-1:0]             stop_i
);

  noc_pkg::port_req_t [noc_pkg::num_ports-1:0] reqs;

  // read strobes, first index output, second index input
  logic [noc_pkg::num_ports-1:0][noc_pkg::num_ports-1:0] rd_strobe;
  logic [noc_pkg::num_ports-1:0]                         rd_any;

  always_comb begin
    for (int i = 0; i < noc_pkg::num_ports; i++) begin
      rd_any[i] = 1'b0;
      for (int o = 0; o < noc_pkg::num_ports; o++) begin
        rd_any[i] = rd_any[i] | rd_strobe[o][i];
      end
    end
  end

  //////////////////////////////
  // ports
  //////////////////////////////

  for (genvar g = 0; g < noc_pkg::num_ports; g++) begin : gen_port

    input_port u_in (
      .clk         (clk),
      .rst         (rst),
      .data_i      (data_i[g]),
      .data_void_i (data_void_i[g]),
      .rd_i        (rd_any[g]),
      .stop_o      (stop_o[g]),
      .req_o       (reqs[g])
    );

    output_port #(
      .out_port (noc_pkg::port_e'(g))
    ) u_out (
      .clk         (clk),
      .rst         (rst),
      .position_i  (position_i),
      .reqs_i      (reqs),
      .stop_i      (stop_i[g]),
      .rd_o        (rd_strobe[g]),
      .data_o      (data_o[g]),
      .data_void_o (data_void_o[g])
    );

  end

endmodule

// ==== tb/router_properties.sv ====
// output port assertions

module router_properties (
  input logic                          clk,
  input logic                          rst,
  input logic [noc_pkg::num_ports-1:0] grant_i,
  input logic                          stop_i,
  input noc_pkg::flit_t                data_i,
  input logic                          data_void_i
);

  // at most one input owns the output
  a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant_i))
    else $error("output grant has more than one bit set");

  // downstream stop freezes the output register
  a_void_hold: assert property (@(posedge clk) disable iff (rst) stop_i |=> $stable(data_void_i))
    else $error("output void bit changed while stop was high");

  a_data_hold: assert property (@(posedge clk) disable iff (rst)
    (stop_i && !data_void_i) |=> $stable(data_i))
    else $error("output flit changed while stop was high");

  a_void_after_reset: assert property (@(posedge clk) $fell(rst) |-> data_void_i)
    else $error("output void bit low right after reset");

endmodule

bind output_port router_properties u_props (
  .clk         (clk),
  .rst         (rst),
  .grant_i     (grant),
  .stop_i      (stop_i),
  .data_i      (data_o),
  .data_void_i (data_void_o)
);

// ==== tb/router_tb.sv ====
// mesh router testbench
// random worms checked against a queue model

module router_tb;

  localparam int np          = noc_pkg::num_ports;
  localparam int drain_limit = 3000;

  logic                    clk;
  logic                    rst;
  noc_pkg::xy_t            position;
  noc_pkg::flit_t [np-1:0] data_in;
  logic [np-1:0]           void_in;
  logic [np-1:0]           stop_out;
  noc_pkg::flit_t [np-1:0] data_out;
  logic [np-1:0]           void_out;
  logic [np-1:0]           stop_in;

  integer seed = 98;

  // expected flits, index is input * np + output
  noc_pkg::flit_t exp_q [np*np][$];

  int cur_in [np];
  int pending [np];
  int rem [np];
  int worm_out [np];
  int worms_left [np];
  int span [np];

  int    max_len;
  logic  bp_on;
  logic  fix_dst;
  string test_name;
  int    errors;
  int    flits;
  int    tests_run;
  int    tests_failed;

  mesh_router UUT (
    .clk         (clk),
    .rst         (rst),
    .position_i  (position),
    .data_i      (data_in),
    .data_void_i (void_in),
    .stop_o      (stop_out),
    .data_o      (data_out),
    .data_void_o (void_out),
    .stop_i      (stop_in)
  );

  always #2 clk = ~clk;

  //////////////////////////////
  // routing rule
  //////////////////////////////

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // x first, then y; east is x + 1, north is y - 1
  function automatic int xy_port(noc_pkg::xy_t here, noc_pkg::xy_t dst);
    if (dst.x != here.x) begin
      return (dst.x > here.x) ? 3 : 2;
    end
    if (dst.y != here.y) begin
      return (dst.y > here.y) ? 1 : 0;
    end
    return 4;
  endfunction

  function automatic noc_pkg::xy_t neighbor(noc_pkg::xy_t here, int o);
    noc_pkg::xy_t n;
    n = here;
    case (o)
      0: n.y = here.y - 3'd1;
      1: n.y = here.y + 3'd1;
      2: n.x = here.x - 3'd1;
      3: n.x = here.x + 3'd1;
      default: n = here;
    endcase
    return n;
  endfunction

  // head as it should leave through output o
  function automatic noc_pkg::flit_t expect_head(noc_pkg::flit_t f, int o);
    noc_pkg::header_t h;
    h = noc_pkg::header_t'(f.data);
    h.routing = 5'b00001 << xy_port(neighbor(position, o), h.dst);
    f.data = h;
    return f;
  endfunction

  task automatic report_error(string msg);
    $display("%s", msg);
    errors++;
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  task automatic drive_input(int i);
    noc_pkg::header_t h;
    noc_pkg::flit_t   f;
    noc_pkg::xy_t     dst;
    logic [31:0]      r;
    void_in[i] = 1'b1;
    if (stop_out[i] || (rem[i] == 0 && worms_left[i] == 0) || rand_below(4) == 0) begin
      return;
    end
    if (rem[i] == 0) begin
      dst.x = fix_dst ? 3'd5 : (rand_below(3) == 0 ? 3'd3 : 3'(rand_below(8)));
      dst.y = fix_dst ? 3'd3 : (rand_below(3) == 0 ? 3'd3 : 3'(rand_below(8)));
      r = $random(seed);
      h.src.x = 3'(i);
      h.src.y = 3'd0;
      h.dst = dst;
      h.reserved = r[noc_pkg::hdr_rsv_w-1:0];
      h.routing = 5'b00001 << xy_port(position, dst);
      f.head = 1'b1;
      f.data = h;
      rem[i] = 1 + rand_below(max_len);
      worm_out[i] = xy_port(position, dst);
      worms_left[i]--;
    end else begin
      f.head = 1'b0;
      f.data = $random(seed);
    end
    f.tail = (rem[i] == 1);
    rem[i]--;
    data_in[i] = f;
    void_in[i] = 1'b0;
    exp_q[i*np+worm_out[i]].push_back(f.head ? expect_head(f, worm_out[i]) : f);
    pending[i]++;
  endtask

  always @(posedge clk) begin
    #1;
    for (int i = 0; i < np; i++) begin
      drive_input(i);
    end
    // stop spans per output
    for (int o = 0; o < np; o++) begin
      if (span[o] == 0) begin
        stop_in[o] = bp_on && (rand_below(2) == 0);
        span[o] = rand_below(6);
      end else begin
        span[o]--;
      end
    end
  end

  //////////////////////////////
  // output model
  //////////////////////////////

  task automatic check_output(int o);
    noc_pkg::flit_t   f;
    noc_pkg::header_t h;
    int               src;
    int               k;
    f = data_out[o];
    h = noc_pkg::header_t'(f.data);
    src = cur_in[o];
    if (f.head) begin
      if (cur_in[o] >= 0) begin
        report_error($sformatf("%s: head on output %0d inside a worm from input %0d",
                               test_name, o, cur_in[o]));
      end
      src = int'(h.src.x);
    end
    if (src < 0 || src >= np || exp_q[src*np+o].size() == 0) begin
      report_error($sformatf("%s: unexpected flit %h on output %0d", test_name, f, o));
      return;
    end
    k = src * np + o;
    if (exp_q[k][0] != f) begin
      report_error($sformatf("mismatch %s output %0d: expected %h actual %h",
                             test_name, o, exp_q[k][0], f));
    end
    void'(exp_q[k].pop_front());
    pending[src]--;
    flits++;
    cur_in[o] = f.tail ? -1 : src;
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      for (int i = 0; i < np; i++) begin
        if (stop_out[i] && pending[i] < noc_pkg::fifo_depth) begin
          report_error($sformatf("%s: stop_o of input %0d high with %0d flits waiting",
                                 test_name, i, pending[i]));
        end
      end
      for (int o = 0; o < np; o++) begin
        if (!void_out[o] && !stop_in[o]) begin
          check_output(o);
        end
      end
    end
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  function automatic logic all_idle();
    for (int i = 0; i < np; i++) begin
      if (worms_left[i] != 0 || rem[i] != 0) begin
        return 1'b0;
      end
    end
    for (int k = 0; k < np * np; k++) begin
      if (exp_q[k].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic run_test(string name, int worms, int len_max, logic bp, logic fix);
    int waited;
    int errs_before;
    int flits_before;
    test_name = name;
    errs_before = errors;
    flits_before = flits;
    max_len = len_max;
    bp_on = bp;
    fix_dst = fix;
    for (int i = 0; i < np; i++) begin
      worms_left[i] = worms;
    end
    waited = 0;
    while (!all_idle() && waited < drain_limit) begin
      @(posedge clk);
      waited++;
    end
    if (!all_idle()) begin
      report_error($sformatf("%s: timeout with worms still in flight", name));
    end
    bp_on = 1'b0;
    tests_run++;
    if (errors != errs_before) begin
      tests_failed++;
    end
    $display("test %s finished: %0d flits, %0d errors", name, flits - flits_before,
             errors - errs_before);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    position.x = 3'd3;
    position.y = 3'd3;
    data_in = '0;
    void_in = '1;
    stop_in = '0;
    bp_on = 1'b0;
    fix_dst = 1'b0;
    max_len = 1;
    test_name = "reset";
    for (int i = 0; i < np; i++) begin
      cur_in[i] = -1;
      pending[i] = 0;
      rem[i] = 0;
      worm_out[i] = 0;
      worms_left[i] = 0;
      span[i] = 0;
    end
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    if (void_out != '1 || stop_out != '0) begin
      report_error($sformatf("mismatch reset: expected void %b stop %b actual void %b stop %b",
                             5'b11111, 5'b00000, void_out, stop_out));
    end
    tests_run++;
    if (errors != 0) begin
      tests_failed++;
    end
    $display("test reset finished: %0d errors", errors);
    @(posedge clk);
    run_test("single_flit", 12, 1, 1'b0, 1'b0);
    run_test("multi_flit", 12, 4, 1'b0, 1'b0);
    run_test("contention", 8, 4, 1'b0, 1'b1);
    run_test("back_pressure", 16, 4, 1'b1, 1'b0);
    $display("tests %0d, failed %0d, errors %0d, flits %0d",
             tests_run, tests_failed, errors, flits);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== all.f ====
logic/noc_pkg.sv
logic/input_port.sv
logic/wormhole_arbiter.sv
logic/lookahead_route.sv
logic/output_port.sv
logic/mesh_router.sv
tb/router_properties.sv
tb/router_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= router_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= === PASS ===
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF -- "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
